// ==== verilog/memPkg.sv ====
package memPkg;

	// status word shared by the register side and the memory bus
	localparam logic [1:0] okReady = 2'd0;
	localparam logic [1:0] okOk    = 2'd1;
	localparam logic [1:0] okHold  = 2'd2;

	localparam logic [4:0] opmReady  = 5'b00000;	// no operation
	// line transfers, both top bits set so they never look like a load or store
	localparam logic [4:0] opmRdTile = 5'b11000;
	localparam logic [4:0] opmWrTile = 5'b11001;

	// cache geometry
	localparam int lineBytes = 16;
	localparam int bankSets  = 64;
	localparam int setIxW    = 6;
	localparam int lineAddrW = 28;

	localparam logic [3:0] mmioNibble = 4'hA;

	// tile memory
	localparam int tileWords   = 1024;
	localparam int tileLatency = 3;

	// miss sequencer states
	localparam logic [2:0] msIdle     = 3'd0;
	localparam logic [2:0] msWb       = 3'd1;
	localparam logic [2:0] msRd       = 3'd2;
	localparam logic [2:0] msRefill   = 3'd3;
	localparam logic [2:0] msMmio     = 3'd4;
	localparam logic [2:0] msMmioDone = 3'd5;

	typedef struct packed {
		logic       isStore;
		logic       isLoad;
		logic       isUnsigned;
		logic [1:0] size;	// 8, 16, 32, 64 bits
	} memOpmS;

	// raw word for bus codes, fields for the register-side decode
	typedef union packed {
		logic [4:0] raw;
		memOpmS     f;
	} memOpmU;

endpackage

// ==== verilog/dcacheBank.sv ====
`timescale 1ns/1ps

module dcacheBank
	import memPkg::*;
#(
	parameter bit bankOdd = 1'b0	// set for the bank holding odd lines
)
(
	input  logic                 clock,
	input  logic                 rstN,
	input  logic [setIxW-1:0]    rdIx,
	input  logic                 wrEn,
	input  logic [setIxW-1:0]    wrIx,
	input  logic [lineAddrW-1:0] wrTag,
	input  logic                 wrDirty,
	input  logic [127:0]         wrData,
	output logic [lineAddrW-1:0] rdTag,
	output logic                 rdValid,
	output logic                 rdDirty,
	output logic [127:0]         rdData
);

	logic [lineAddrW-1:0] tagMem [bankSets];
	logic [127:0]         dataMem [bankSets];
	logic [bankSets-1:0]  validBits;
	logic [bankSets-1:0]  dirtyBits;
	logic                 bypass;

	assign bypass = wrEn && (wrIx == rdIx);	// same-cycle write wins

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			validBits <= '0;
			dirtyBits <= '0;
			rdValid   <= 1'b0;
			rdDirty   <= 1'b0;
		end
		else
		begin
			if (wrEn)
			begin
				validBits[wrIx] <= 1'b1;
				dirtyBits[wrIx] <= wrDirty;
			end
			rdValid <= bypass ? 1'b1 : validBits[rdIx];
			rdDirty <= bypass ? wrDirty : dirtyBits[rdIx];
		end
	end

	always_ff @(posedge clock)
	begin
		if (wrEn)
		begin
			tagMem[wrIx]  <= wrTag;
			dataMem[wrIx] <= wrData;
		end
		rdTag  <= bypass ? wrTag : tagMem[rdIx];
		rdData <= bypass ? wrData : dataMem[rdIx];
	end

	// even lines live in bank A, odd lines in bank B
	assert property (@(posedge clock) disable iff (!rstN) wrEn |-> wrTag[0] == bankOdd);

endmodule

// ==== verilog/dcacheAlign.sv ====
`timescale 1ns/1ps

module dcacheAlign
	import memPkg::*;
(
	input  logic [4:0]   reqAddr,
	input  memOpmU       opm,
	input  logic [127:0] lineA,
	input  logic [127:0] lineB,
	input  logic [63:0]  storeVal,
	output logic [63:0]  loadVal,
	output logic [127:0] newLineA,
	output logic [127:0] newLineB,
	output logic         touchA,
	output logic         touchB
);

	logic [127:0] window;
	logic [127:0] merged;
	logic [63:0]  extract;
	logic [63:0]  stMerged;
	logic [6:0]   bitOff;
	logic         sx;

	assign bitOff = {1'b0, reqAddr[2:0], 3'b000};

	always_comb
	begin
		// 16-byte window starting at the aligned doubleword
		case (reqAddr[4:3])
			2'b00: window = lineA;
			2'b01: window = {lineB[63:0], lineA[127:64]};
			2'b10: window = lineB;
			default: window = {lineA[63:0], lineB[127:64]};
		endcase

		extract = window[bitOff +: 64];
		sx      = !opm.f.isUnsigned;

		case (opm.f.size)
			2'd0: loadVal = {{56{sx & extract[7]}}, extract[7:0]};
			2'd1: loadVal = {{48{sx & extract[15]}}, extract[15:0]};
			2'd2: loadVal = {{32{sx & extract[31]}}, extract[31:0]};
			default: loadVal = extract;
		endcase

		// keep bytes above the store size
		case (opm.f.size)
			2'd0: stMerged = {extract[63:8], storeVal[7:0]};
			2'd1: stMerged = {extract[63:16], storeVal[15:0]};
			2'd2: stMerged = {extract[63:32], storeVal[31:0]};
			default: stMerged = storeVal;
		endcase

		merged                 = window;
		merged[bitOff +: 64]   = stMerged;

		newLineA = lineA;
		newLineB = lineB;
		case (reqAddr[4:3])
			2'b00: newLineA = merged;
			2'b01:
			begin
				newLineA = {merged[63:0], lineA[63:0]};
				newLineB = {lineB[127:64], merged[127:64]};
			end
			2'b10: newLineB = merged;
			default:
			begin
				newLineB = {merged[63:0], lineB[63:0]};
				newLineA = {lineA[127:64], merged[127:64]};
			end
		endcase
	end

	assign touchA = opm.f.isStore && (reqAddr[4:3] != 2'b10);
	assign touchB = opm.f.isStore && (reqAddr[4:3] != 2'b00);

endmodule

// ==== verilog/dcacheMissCtl.sv ====
`timescale 1ns/1ps

module dcacheMissCtl
	import memPkg::*;
(
	input  logic                 clock,
	input  logic                 rstN,
	input  logic                 missA,
	input  logic                 missB,
	input  logic                 isMmio,
	input  memOpmU               reqOpm,
	input  logic [31:0]          reqAddr,
	input  logic [63:0]          reqVal,
	input  logic [lineAddrW-1:0] reqLineA,
	input  logic [lineAddrW-1:0] reqLineB,
	input  logic [lineAddrW-1:0] victimTagA,
	input  logic [lineAddrW-1:0] victimTagB,
	input  logic                 victimDirtyA,
	input  logic                 victimDirtyB,
	input  logic [127:0]         victimDataA,
	input  logic [127:0]         victimDataB,
	input  logic [127:0]         memDataIn,
	input  logic [1:0]           memOK,
	output logic [31:0]          memAddr,
	output memOpmU               memOpm,
	output logic [127:0]         memDataOut,
	output logic                 refillA,
	output logic                 refillB,
	output logic [127:0]         refillData,
	output logic                 busy,
	output logic                 mmioDone,
	output logic [63:0]          mmioVal
);

	logic [2:0]   state;
	logic         active;	// transfer issued, waiting for okOk
	logic         sideB;
	logic         issue;
	logic         done;
	logic [31:0]  nextAddr;
	memOpmU       nextOpm;
	logic [127:0] nextData;

	assign issue = (state == msWb || state == msRd || state == msMmio)
		&& !active && memOK == okReady;
	assign done = active && memOK == okOk;

	always_comb
	begin
		case (state)
			msWb:
			begin
				nextAddr    = {sideB ? victimTagB : victimTagA, 4'b0000};
				nextOpm.raw = opmWrTile;
				nextData    = sideB ? victimDataB : victimDataA;
			end
			msRd:
			begin
				nextAddr    = {sideB ? reqLineB : reqLineA, 4'b0000};
				nextOpm.raw = opmRdTile;
				nextData    = '0;
			end
			default:
			begin
				nextAddr = reqAddr;	// MMIO passes through unchanged
				nextOpm  = reqOpm;
				nextData = {64'd0, reqVal};
			end
		endcase
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			state      <= msIdle;
			active     <= 1'b0;
			sideB      <= 1'b0;
			memOpm.raw <= opmReady;
		end
		else
		begin
			case (state)
				msIdle:
				begin
					if (missA || missB)
					begin
						sideB <= !missA;	// bank A first
						if (missA ? victimDirtyA : victimDirtyB)
							state <= msWb;
						else
							state <= msRd;
					end
					else if (isMmio)
						state <= msMmio;
				end
				msRefill, msMmioDone: state <= msIdle;
				default:
				begin
					if (issue)
					begin
						memOpm <= nextOpm;
						active <= 1'b1;
					end
					else if (done)
					begin
						memOpm.raw <= opmReady;
						active     <= 1'b0;
						if (state == msWb)
							state <= msRd;
						else if (state == msRd)
							state <= msRefill;
						else
							state <= msMmioDone;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (issue)
		begin
			memAddr    <= nextAddr;
			memDataOut <= nextData;
		end
		if (done && state == msRd)
			refillData <= memDataIn;
		if (done && state == msMmio)
			mmioVal <= memDataIn[63:0];	// low half only
	end

	assign refillA  = (state == msRefill) && !sideB;
	assign refillB  = (state == msRefill) && sideB;
	assign busy     = (state == msWb) || (state == msRd) || (state == msRefill);
	assign mmioDone = (state == msMmioDone);

	// a hold from the tile memory always belongs to a transfer opened here
	assert property (@(posedge clock) disable iff (!rstN)
		memOK == okHold |-> active && memOpm.raw != opmReady);

endmodule

// ==== verilog/memDcache.sv ====
`timescale 1ns/1ps

module memDcache
	import memPkg::*;
(
	input  logic         clock,
	input  logic         rstN,
	input  logic [31:0]  regInAddr,
	input  memOpmU       regInOpm,
	input  logic [63:0]  regInVal,
	output logic [63:0]  regOutVal,
	output logic [1:0]   regOutOK,
	output logic [31:0]  memAddr,
	output memOpmU       memOpm,
	output logic [127:0] memDataOut,
	input  logic [127:0] memDataIn,
	input  logic [1:0]   memOK
);

	logic [lineAddrW-1:0] nxtLineA, nxtLineB, reqLineA, reqLineB;
	logic [setIxW-1:0]    rdIxA, rdIxB, reqIxA, reqIxB;
	logic [31:0]          reqAddr;
	memOpmU               reqOpm;
	logic [63:0]          reqVal;
	logic                 reqIsMmio;
	logic [lineAddrW-1:0] tagA, tagB;
	logic                 validA, validB, dirtyA, dirtyB;
	logic [127:0]         dataA, dataB, newLineA, newLineB, refillData;
	logic                 reqLive, cacheReq, missA, missB, hold, storeEn;
	logic                 touchA, touchB, refillA, refillB, busy, mmioDone;
	logic [63:0]          loadVal, mmioVal;

	always_comb
	begin
		if (regInAddr[4])
		begin
			nxtLineB = regInAddr[31:4];
			nxtLineA = regInAddr[31:4] + 1'b1;
		end
		else
		begin
			nxtLineA = regInAddr[31:4];
			nxtLineB = regInAddr[31:4] + 1'b1;
		end
	end

	assign reqIxA = reqLineA[setIxW:1];
	assign reqIxB = reqLineB[setIxW:1];
	assign rdIxA  = hold ? reqIxA : nxtLineA[setIxW:1];	// replay while held
	assign rdIxB  = hold ? reqIxB : nxtLineB[setIxW:1];

	assign reqLive  = reqOpm.raw != opmReady;
	assign cacheReq = reqLive && !reqIsMmio;
	// a bank only matters when the window reaches into it
	assign missA = cacheReq && (reqAddr[4:3] != 2'b10) && !(validA && tagA == reqLineA);
	assign missB = cacheReq && (reqAddr[4:3] != 2'b00) && !(validB && tagB == reqLineB);
	assign hold  = reqLive && (reqIsMmio ? !mmioDone : (missA || missB || busy));
	assign storeEn = cacheReq && reqOpm.f.isStore && !hold;

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			reqOpm.raw <= opmReady;
			regOutOK   <= okReady;
		end
		else
		begin
			if (!hold)
				reqOpm <= regInOpm;
			regOutOK <= hold ? okHold : (reqLive ? okOk : okReady);
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			reqAddr   <= regInAddr;
			reqVal    <= regInVal;
			reqLineA  <= nxtLineA;
			reqLineB  <= nxtLineB;
			reqIsMmio <= regInAddr[31:28] == mmioNibble;
		end
		regOutVal <= reqIsMmio ? mmioVal : loadVal;
	end

	dcacheBank #(.bankOdd(1'b0)) bankEven (
		.clock(clock), .rstN(rstN), .rdIx(rdIxA),
		.wrEn(refillA || (storeEn && touchA)), .wrIx(reqIxA), .wrTag(reqLineA),
		.wrDirty(!refillA), .wrData(refillA ? refillData : newLineA),
		.rdTag(tagA), .rdValid(validA), .rdDirty(dirtyA), .rdData(dataA)
	);

	dcacheBank #(.bankOdd(1'b1)) bankOdd (
		.clock(clock), .rstN(rstN), .rdIx(rdIxB),
		.wrEn(refillB || (storeEn && touchB)), .wrIx(reqIxB), .wrTag(reqLineB),
		.wrDirty(!refillB), .wrData(refillB ? refillData : newLineB),
		.rdTag(tagB), .rdValid(validB), .rdDirty(dirtyB), .rdData(dataB)
	);

	dcacheAlign align (
		.reqAddr(reqAddr[4:0]), .opm(reqOpm), .lineA(dataA), .lineB(dataB),
		.storeVal(reqVal), .loadVal(loadVal), .newLineA(newLineA),
		.newLineB(newLineB), .touchA(touchA), .touchB(touchB)
	);

	dcacheMissCtl missCtl (
		.clock(clock), .rstN(rstN), .missA(missA), .missB(missB),
		.isMmio(reqLive && reqIsMmio), .reqOpm(reqOpm), .reqAddr(reqAddr),
		.reqVal(reqVal), .reqLineA(reqLineA), .reqLineB(reqLineB),
		.victimTagA(tagA), .victimTagB(tagB),
		.victimDirtyA(validA && dirtyA), .victimDirtyB(validB && dirtyB),
		.victimDataA(dataA), .victimDataB(dataB),
		.memDataIn(memDataIn), .memOK(memOK), .memAddr(memAddr), .memOpm(memOpm),
		.memDataOut(memDataOut), .refillA(refillA), .refillB(refillB),
		.refillData(refillData), .busy(busy), .mmioDone(mmioDone), .mmioVal(mmioVal)
	);

	// store and refill never share a bank write port
	assert property (@(posedge clock) disable iff (!rstN)
		!(storeEn && ((touchA && refillA) || (touchB && refillB))));

endmodule

// ==== verilog/tileMem.sv ====
`timescale 1ns/1ps

module tileMem
	import memPkg::*;
(
	input  logic         clock,
	input  logic         rstN,
	input  logic [31:0]  memAddr,
	input  memOpmU       memOpm,
	input  logic [127:0] memDataOut,
	output logic [127:0] memDataIn,
	output logic [1:0]   memOK
);

	logic [127:0] ram [tileWords];
	logic [63:0]  mmioRegs [16];	// scratch registers
	logic [1:0]   cnt;
	logic         doAccess;

	// preset contents, byte at a is a[7:0] ^ a[15:8]
	initial
	begin
		logic [15:0] a;
		for (int w = 0; w < tileWords; w++)
		begin
			for (int b = 0; b < lineBytes; b++)
			begin
				a = 16'(w * lineBytes + b);
				ram[w][8*b +: 8] = a[7:0] ^ a[15:8];
			end
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			memOK <= okReady;
			cnt   <= '0;
		end
		else
		begin
			case (memOK)
				okReady:
				begin
					if (memOpm.raw != opmReady)
					begin
						memOK <= okHold;
						cnt   <= 2'(tileLatency - 1);
					end
				end
				okHold:
				begin
					if (cnt == '0)
						memOK <= okOk;
					else
						cnt <= cnt - 1'b1;
				end
				default:
				begin
					if (memOpm.raw == opmReady)	// master released the bus
						memOK <= okReady;
				end
			endcase
		end
	end

	assign doAccess = (memOK == okHold) && (cnt == '0);

	always @(posedge clock)
	begin
		if (doAccess)
		begin
			// tile codes first, they also carry the store bit
			if (memOpm.raw == opmRdTile)
				memDataIn <= ram[memAddr[13:4]];
			else if (memOpm.raw == opmWrTile)
				ram[memAddr[13:4]] <= memDataOut;
			else if (memOpm.f.isStore)
				mmioRegs[memAddr[6:3]] <= memDataOut[63:0];
			else
				memDataIn <= {64'd0, mmioRegs[memAddr[6:3]]};
		end
	end

endmodule

// ==== verilog/memSubsys.sv ====
`timescale 1ns/1ps

module memSubsys
	import memPkg::*;
(
	input  logic        clock,
	input  logic        rstN,
	input  logic [31:0] regInAddr,
	input  memOpmU      regInOpm,
	input  logic [63:0] regInVal,
	output logic [63:0] regOutVal,
	output logic [1:0]  regOutOK
);

	logic [31:0]  memAddr;
	memOpmU       memOpm;
	logic [127:0] memDataOut;
	logic [127:0] memDataIn;
	logic [1:0]   memOK;

	memDcache cache (
		.clock(clock), .rstN(rstN), .regInAddr(regInAddr), .regInOpm(regInOpm),
		.regInVal(regInVal), .regOutVal(regOutVal), .regOutOK(regOutOK),
		.memAddr(memAddr), .memOpm(memOpm), .memDataOut(memDataOut),
		.memDataIn(memDataIn), .memOK(memOK)
	);

	tileMem tile (
		.clock(clock), .rstN(rstN), .memAddr(memAddr), .memOpm(memOpm),
		.memDataOut(memDataOut), .memDataIn(memDataIn), .memOK(memOK)
	);

endmodule

// ==== dv/tbMemSubsys.sv ====
`timescale 1ns/1ps

module tbMemSubsys
	import memPkg::*;
();

	localparam int maxRecs       = 64;
	localparam int fields        = 5;	// opm, address, store data, expected, flags
	localparam int timeoutCycles = 200;

	logic        clock = 1'b0;
	logic        rstN;
	logic [31:0] regInAddr;
	memOpmU      regInOpm;
	logic [63:0] regInVal;
	logic [63:0] regOutVal;
	logic [1:0]  regOutOK;

	logic [63:0] golden [maxRecs*fields];
	logic [63:0] expVal [$];	// one entry per request still in flight
	logic        expMasked [$];
	int          expId [$];
	int          numRecs;
	int          valueErrors;
	int          statusErrors;
	int          timeouts;

	memSubsys i_dut (
		.clock(clock), .rstN(rstN), .regInAddr(regInAddr), .regInOpm(regInOpm),
		.regInVal(regInVal), .regOutVal(regOutVal), .regOutOK(regOutOK)
	);

	always #5 clock = !clock;

	task automatic driveIdle();
		regInOpm.raw = opmReady;
		regInAddr    = '0;
		regInVal     = '0;
	endtask

	task automatic driveRecord(input int r);
		int b;
		b = r * fields;
		regInOpm.raw = golden[b][4:0];
		regInAddr    = golden[b + 1][31:0];
		regInVal     = golden[b + 2];
		expVal.push_back(golden[b + 3]);
		expMasked.push_back(golden[b + 4][0]);
		expId.push_back(r);
	endtask

	// oldest request in flight gets this okOk
	task automatic checkResponse();
		logic [63:0] exp;
		logic        masked;
		int          id;
		exp    = expVal.pop_front();
		masked = expMasked.pop_front();
		id     = expId.pop_front();
		if (!masked)
		begin
			assert (regOutVal == exp) else
			begin
				$display("** Error at %0t: request %0d returned %h, expected %h",
					$time, id, regOutVal, exp);
				valueErrors++;
			end
		end
	endtask

	function automatic int pickGap(input int r);
		if (r < numRecs && golden[r * fields + 4][1])
			return 0;	// issued right behind the previous request
		return int'($urandom_range(3, 0));
	endfunction

	initial
	begin
		int          recIdx;
		int          gapLeft;
		int          stall;
		logic        idle;
		logic [1:0]  status;

		void'($urandom(7));
		valueErrors  = 0;
		statusErrors = 0;
		timeouts     = 0;
		rstN         = 1'b0;
		driveIdle();

		$readmemh("dv/dcGolden.txt", golden);
		numRecs = 0;
		while (numRecs < maxRecs && golden[numRecs * fields] != 64'hff)
			numRecs++;

		repeat (5) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;

		recIdx  = 0;
		stall   = 0;
		gapLeft = pickGap(0);
		while ((recIdx < numRecs || expVal.size() != 0) && stall <= timeoutCycles)
		begin
			@(negedge clock);
			status = regOutOK;
			idle   = expVal.size() == 0;

			// nothing in flight means the cache must sit at okReady
			assert (!idle || status == okReady) else
			begin
				$display("** Error at %0t: status %0d with no request in flight", $time, status);
				statusErrors++;
			end
			if (status == okOk && !idle)
				checkResponse();

			if (status == okOk || (idle && status == okReady))
				stall = 0;
			else
				stall++;

			// inputs stay put while the cache holds
			if (status != okHold)
			begin
				if (gapLeft > 0)
				begin
					driveIdle();
					gapLeft--;
				end
				else if (recIdx < numRecs)
				begin
					driveRecord(recIdx);
					recIdx++;
					gapLeft = pickGap(recIdx);
				end
				else
					driveIdle();
			end
		end

		if (stall > timeoutCycles)
		begin
			$display("timeout: cache gave no okOk for %0d cycles, %0d requests still open",
				timeoutCycles, expVal.size());
			timeouts++;
		end

		$display("errors: %0d value, %0d status, %0d timeout", valueErrors, statusErrors,
			timeouts);
		if (valueErrors + statusErrors + timeouts == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== dv/dcGolden.txt ====
// opm  address  store data  expected load value  flags (bit 0 skips the value check, bit 1 = no gap)
// one request per line, the list ends with an opm of ff
0b 00000000 0                0706050403020100 0
0c 00000085 0                0000000000000085 0
08 00000085 0                ffffffffffffff85 0
0d 00000086 0                0000000000008786 0
09 00000086 0                ffffffffffff8786 0
0e 00000094 0                0000000097969594 0
0a 00000094 0                ffffffff97969594 0
0a 00000044 0                0000000047464544 0
0f 000000f8 0                fffefdfcfbfaf9f8 0
10 00000020 ab               0                1
11 00000022 beef             0                1
12 00000024 12345678         0                1
0b 00000020 0                12345678beef21ab 0
13 0000002c 1122334455667788 0                1
0b 0000002c 0                1122334455667788 0
0e 0000002e 0                0000000033445566 0
09 0000002f 0                0000000000004455 0
11 0000003f 9a7b             0                1
09 0000003f 0                ffffffffffff9a7b 0
0f 00000038 0                7b3e3d3c3b3a3938 0
13 00000050 cafef00ddeadbeef 0                1
0b 00000850 0                5f5e5d5c5b5a5958 0
0b 00000050 0                cafef00ddeadbeef 0
0c 00000857 0                000000000000005f 0
0c 00000057 0                00000000000000ca 0
13 a0000010 0123456789abcdef 0                1
0b a0000010 0                0123456789abcdef 0
0b 00000010 0                1716151413121110 0
0b 00000020 0                12345678beef21ab 0
0c 0000003f 0                000000000000007b 2
12 00000008 deadbeef         0                3
0b 00000008 0                0f0e0d0cdeadbeef 2
0a 00000094 0                ffffffff97969594 2
0b 0000002c 0                1122334455667788 2
08 00000050 0                ffffffffffffffef 2
0b 00000040 0                474645444342419a 2
ff 00000000 0                0                0

// ==== tb.f ====
verilog/memPkg.sv
verilog/dcacheBank.sv
verilog/dcacheAlign.sv
verilog/dcacheMissCtl.sv
verilog/memDcache.sv
verilog/tileMem.sv
verilog/memSubsys.sv
dv/tbMemSubsys.sv

// ==== run.sh ====
#!/bin/sh
# build and run the data cache testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f tb.f --top-module tbMemSubsys -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0
